/* hw/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    localparam int data_w     = 32;
    localparam int sh_w       = 5;   // shift amount bits
    localparam int div_cycles = 33;  // load edge plus 32 steps

    // one-hot operation word, mtlo ends up at bit 0
    typedef struct packed {
        logic add;
        logic sub;
        logic slt;
        logic sltu;
        logic and_op;
        logic nor_op;
        logic or_op;
        logic xor_op;
        logic sll;
        logic srl;
        logic sra;
        logic lui;
        logic div;
        logic divu;
        logic mult;
        logic multu;
        logic mfhi;
        logic mflo;
        logic mthi;
        logic mtlo;
    } alu_op_t;

    // instructions that trap on signed overflow
    typedef struct packed {
        logic add;
        logic addi;
        logic sub;
    } ovf_chk_t;

    typedef struct packed {
        logic es;  // execute
        logic m1;
        logic ms;
        logic ws;  // writeback
    } stage_ex_t;

    typedef struct packed {
        logic [data_w-1:0] quot;
        logic [data_w-1:0] rem;
    } div_res_t;

endpackage

`default_nettype wire

/* hw/alu_adder.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_adder (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic              subtract,
    input  alu_pkg::ovf_chk_t ovf_chk,
    output logic [31:0]       sum,
    output logic              slt_bit,
    output logic              sltu_bit,
    output logic              ovf
);
    import alu_pkg::*;

    logic [data_w-1:0] b_eff;
    logic              cout;
    logic              sa;
    logic              sb;
    logic              ss;

    assign b_eff = subtract ? ~b : b;  // two's complement via carry-in
    assign {cout, sum} = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, subtract};

    assign sa = a[data_w-1];
    assign sb = b[data_w-1];
    assign ss = sum[data_w-1];

    // a < b when a negative and b not, or same signs and difference negative
    assign slt_bit  = (sa & ~sb) | (~(sa ^ sb) & ss);
    assign sltu_bit = ~cout;  // borrow out

    always_comb begin
        if (ovf_chk.add || ovf_chk.addi)
            ovf = (sa == sb) && (ss != sa);  // like signs, sum flips
        else if (ovf_chk.sub)
            ovf = (sa != sb) && (ss != sa);
        else
            ovf = 1'b0;
    end

endmodule

`default_nettype wire

/* hw/alu_logic_shift.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_logic_shift (
    input  alu_pkg::alu_op_t op,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [31:0]      y
);
    import alu_pkg::*;

    logic [sh_w-1:0]     shamt;
    logic [data_w-1:0]   lui_val;
    logic [2*data_w-1:0] sr64;   // upper half is the fill

    assign shamt   = a[sh_w-1:0];
    assign lui_val = {b[15:0], 16'b0};

    // srl and sra share one right shift, sra fills with the sign
    assign sr64 = {{data_w{op.sra & b[data_w-1]}}, b} >> shamt;

    assign y = ({data_w{op.and_op}}       & (a & b))
             | ({data_w{op.or_op}}        & (a | b))
             | ({data_w{op.nor_op}}       & ~(a | b))
             | ({data_w{op.xor_op}}       & (a ^ b))
             | ({data_w{op.lui}}          & lui_val)
             | ({data_w{op.sll}}          & (b << shamt))
             | ({data_w{op.srl | op.sra}} & sr64[data_w-1:0]);

endmodule

`default_nettype wire

/* hw/div_iter.sv */
`timescale 1ns/10ps
`default_nettype none

module div_iter (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              is_signed,
    input  logic [31:0]       dividend,
    input  logic [31:0]       divisor,
    output logic              done,
    output alu_pkg::div_res_t res
);
    import alu_pkg::*;

    logic              busy;
    logic [5:0]        cnt;      // steps left
    logic [data_w-1:0] quo;      // dividend shifts out, quotient bits shift in
    logic [data_w-1:0] rem;      // partial remainder
    logic [data_w-1:0] dvs;
    logic              q_neg;
    logic              r_neg;
    logic [data_w-1:0] dvd_mag;
    logic [data_w-1:0] dvs_mag;
    logic [data_w:0]   trial;
    logic [data_w:0]   diff;
    logic [data_w-1:0] quo_nxt;
    logic [data_w-1:0] rem_nxt;
    logic              load;

    assign load = start & ~busy;  // start while busy is dropped

    assign dvd_mag = (is_signed & dividend[data_w-1]) ? -dividend : dividend;
    assign dvs_mag = (is_signed & divisor[data_w-1]) ? -divisor : divisor;

    // one restoring step
    assign trial = {rem, quo[data_w-1]};
    assign diff  = trial - {1'b0, dvs};

    always_comb begin
        if (diff[data_w]) begin  // went negative, keep old remainder
            rem_nxt = trial[data_w-1:0];
            quo_nxt = {quo[data_w-2:0], 1'b0};
        end else begin
            rem_nxt = diff[data_w-1:0];
            quo_nxt = {quo[data_w-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load) begin
                busy <= 1'b1;
                cnt  <= 6'(data_w);
            end else if (busy) begin
                cnt <= cnt - 6'd1;
                if (cnt == 6'd1) begin  // last step
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quo   <= dvd_mag;
            rem   <= '0;
            dvs   <= dvs_mag;
            q_neg <= is_signed & (dividend[data_w-1] ^ divisor[data_w-1]);
            r_neg <= is_signed & dividend[data_w-1];  // remainder follows dividend
        end else if (busy) begin
            quo <= quo_nxt;
            rem <= rem_nxt;
            if (cnt == 6'd1) begin
                res.quot <= q_neg ? -quo_nxt : quo_nxt;
                res.rem  <= r_neg ? -rem_nxt : rem_nxt;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/hilo_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module hilo_regs (
    input  logic               clk,
    input  logic               reset,
    input  alu_pkg::alu_op_t   op,
    input  alu_pkg::stage_ex_t stage_ex,
    input  logic [31:0]        a,
    input  logic [63:0]        prod_s,
    input  logic [63:0]        prod_u,
    input  alu_pkg::div_res_t  div_res,
    input  logic               div_done,
    output logic [31:0]        hi,
    output logic [31:0]        lo
);
    import alu_pkg::*;

    logic wr_ok;

    // no write while a later stage holds an exception
    assign wr_ok = ~|stage_ex;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (wr_ok) begin
            if (div_done && (op.div || op.divu)) begin  // op must still be held
                hi <= div_res.rem;
                lo <= div_res.quot;
            end else if (op.mult) begin
                hi <= prod_s[2*data_w-1:data_w];
                lo <= prod_s[data_w-1:0];
            end else if (op.multu) begin
                hi <= prod_u[2*data_w-1:data_w];
                lo <= prod_u[data_w-1:0];
            end else if (op.mthi) begin
                hi <= a;
            end else if (op.mtlo) begin
                lo <= a;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic               clk,
    input  logic               reset,
    input  alu_pkg::alu_op_t   alu_op,
    input  alu_pkg::ovf_chk_t  ovf_chk,
    input  alu_pkg::stage_ex_t stage_ex,
    input  logic [31:0]        src1,
    input  logic [31:0]        src2,
    output logic [31:0]        result,
    output logic               overflow,
    output logic               div_done
);
    import alu_pkg::*;

    logic [data_w-1:0]   sum;
    logic                slt_bit;
    logic                sltu_bit;
    logic                add_ovf;
    logic                subtract;
    logic [data_w-1:0]   ls_y;
    logic [2*data_w-1:0] prod_s;
    logic [2*data_w-1:0] prod_u;
    div_res_t            div_res;
    logic [data_w-1:0]   hi;
    logic [data_w-1:0]   lo;
    logic                div_req;
    logic                div_held;   // divide already launched for this op
    logic                div_start;

    assign subtract = alu_op.sub | alu_op.slt | alu_op.sltu;

    alu_adder u_adder (
        .a        (src1),
        .b        (src2),
        .subtract (subtract),
        .ovf_chk  (ovf_chk),
        .sum      (sum),
        .slt_bit  (slt_bit),
        .sltu_bit (sltu_bit),
        .ovf      (add_ovf)
    );

    alu_logic_shift u_logic_shift (
        .op (alu_op),
        .a  (src1),
        .b  (src2),
        .y  (ls_y)
    );

    assign prod_s = $signed(src1) * $signed(src2);
    assign prod_u = src1 * src2;

    // level to pulse, a new divide needs the op to drop first
    assign div_req = alu_op.div | alu_op.divu;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_held  <= 1'b0;
            div_start <= 1'b0;
        end else begin
            div_start <= div_req & ~div_held;
            div_held  <= div_req;
        end
    end

    div_iter u_div (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (alu_op.div),
        .dividend  (src1),
        .divisor   (src2),
        .done      (div_done),
        .res       (div_res)
    );

    hilo_regs u_hilo (
        .clk      (clk),
        .reset    (reset),
        .op       (alu_op),
        .stage_ex (stage_ex),
        .a        (src1),
        .prod_s   (prod_s),
        .prod_u   (prod_u),
        .div_res  (div_res),
        .div_done (div_done),
        .hi       (hi),
        .lo       (lo)
    );

    // unselected terms are zero, so a plain OR picks the result
    assign result = ({data_w{alu_op.add | alu_op.sub}} & sum)
                  | {{(data_w-1){1'b0}}, alu_op.slt & slt_bit}
                  | {{(data_w-1){1'b0}}, alu_op.sltu & sltu_bit}
                  | ls_y
                  | ({data_w{alu_op.mfhi}} & hi)
                  | ({data_w{alu_op.mflo}} & lo);

    assign overflow = add_ovf & (|ovf_chk);

endmodule

`default_nettype wire

/* sim/alu_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_checker (
    input  logic             clk,
    input  logic             reset,
    input  alu_pkg::alu_op_t alu_op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    input  logic [31:0]      result,
    input  logic             overflow,
    input  logic             div_done,
    input  logic             exp_valid,
    input  logic [31:0]      exp_result,
    input  logic             exp_ovf,
    output int               err_count,
    output int               check_count
);
    import alu_pkg::*;

    localparam int sample_dly = 7;  // 1 ns before the next rising edge

    logic div_req;
    logic div_prev;
    int   div_edges;  // samples since the divide op first showed up
    time  div_t0;

    assign div_req = alu_op.div | alu_op.divu;

    initial begin
        err_count   = 0;
        check_count = 0;
        div_prev    = 1'b0;
        div_edges   = 0;
        div_t0      = 0;
    end

    always @(posedge clk) begin
        #sample_dly;
        if (reset) begin
            div_prev = 1'b0;
        end else begin
            if (exp_valid) begin
                check_count++;
                if (result !== exp_result || overflow !== exp_ovf) begin
                    err_count++;
                    $display("** Error at %0t: result %h ovf %b, expected %h ovf %b",
                             $time, result, overflow, exp_result, exp_ovf);
                    $display("   op %h src1 %h src2 %h", alu_op, src1, src2);
                end
            end

            // first sample comes before the edge that launches the divide
            if (div_req && !div_prev) begin
                div_edges = 0;
                div_t0    = $time;
            end else if (div_req) begin
                div_edges++;
            end

            if (div_done) begin
                check_count++;
                if (!div_req) begin
                    err_count++;
                    $display("** Error at %0t: div_done with no divide op held", $time);
                end else if (div_edges != div_cycles + 1) begin
                    err_count++;
                    $display("** Error at %0t: div_done after %0d edges, expected %0d",
                             $time, div_edges - 1, div_cycles);
                end
            end else if (div_req && div_edges == div_cycles + 1) begin
                err_count++;
                $display("divide started at %0t never raised div_done within %0d edges",
                         div_t0, div_cycles);
            end
            div_prev = div_req;
        end
    end

endmodule

`default_nettype wire

/* sim/alu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_tb;
    import alu_pkg::*;

    typedef struct packed {
        alu_op_t     op;
        ovf_chk_t    chk;
        stage_ex_t   sx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ovf;
        logic        chk_hilo;  // follow up with mfhi and mflo
        logic [31:0] hi;
        logic [31:0] lo;
    } row_t;

    localparam alu_op_t op_add   = 20'h80000;
    localparam alu_op_t op_sub   = 20'h40000;
    localparam alu_op_t op_slt   = 20'h20000;
    localparam alu_op_t op_sltu  = 20'h10000;
    localparam alu_op_t op_and   = 20'h08000;
    localparam alu_op_t op_nor   = 20'h04000;
    localparam alu_op_t op_or    = 20'h02000;
    localparam alu_op_t op_xor   = 20'h01000;
    localparam alu_op_t op_sll   = 20'h00800;
    localparam alu_op_t op_srl   = 20'h00400;
    localparam alu_op_t op_sra   = 20'h00200;
    localparam alu_op_t op_lui   = 20'h00100;
    localparam alu_op_t op_div   = 20'h00080;
    localparam alu_op_t op_divu  = 20'h00040;
    localparam alu_op_t op_mult  = 20'h00020;
    localparam alu_op_t op_multu = 20'h00010;
    localparam alu_op_t op_mfhi  = 20'h00008;
    localparam alu_op_t op_mflo  = 20'h00004;
    localparam alu_op_t op_mthi  = 20'h00002;
    localparam alu_op_t op_mtlo  = 20'h00001;

    localparam ovf_chk_t  chk_none = 3'b000;
    localparam ovf_chk_t  chk_add  = 3'b100;
    localparam ovf_chk_t  chk_addi = 3'b010;
    localparam ovf_chk_t  chk_sub  = 3'b001;
    localparam stage_ex_t no_ex    = 4'b0000;

    localparam int drive_dly = 1;
    localparam int n_rand    = 40;

    logic        clk;
    logic        reset;
    alu_op_t     alu_op;
    ovf_chk_t    ovf_chk;
    stage_ex_t   stage_ex;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] result;
    logic        overflow;
    logic        div_done;
    logic        exp_valid;
    logic [31:0] exp_result;
    logic        exp_ovf;
    int          err_count;
    int          check_count;
    integer      seed;
    logic [31:0] model_hi;  // HI/LO as the table expects them
    logic [31:0] model_lo;
    row_t        rows[$];
    bit          table_ready;
    int          limit_ns;

    always #4 clk = ~clk;

    alu DUT (
        .clk      (clk),
        .reset    (reset),
        .alu_op   (alu_op),
        .ovf_chk  (ovf_chk),
        .stage_ex (stage_ex),
        .src1     (src1),
        .src2     (src2),
        .result   (result),
        .overflow (overflow),
        .div_done (div_done)
    );

    alu_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .alu_op      (alu_op),
        .src1        (src1),
        .src2        (src2),
        .result      (result),
        .overflow    (overflow),
        .div_done    (div_done),
        .exp_valid   (exp_valid),
        .exp_result  (exp_result),
        .exp_ovf     (exp_ovf),
        .err_count   (err_count),
        .check_count (check_count)
    );

    function automatic logic [31:0] ref_result(alu_op_t op, logic [31:0] a, logic [31:0] b);
        logic [4:0] sh;
        sh = a[4:0];
        if (op.add)    return a + b;
        if (op.sub)    return a - b;
        if (op.slt)    return {31'b0, $signed(a) < $signed(b)};
        if (op.sltu)   return {31'b0, a < b};
        if (op.and_op) return a & b;
        if (op.or_op)  return a | b;
        if (op.nor_op) return ~(a | b);
        if (op.xor_op) return a ^ b;
        if (op.sll)    return b << sh;
        if (op.srl)    return b >> sh;
        if (op.sra)    return $signed(b) >>> sh;
        if (op.lui)    return {b[15:0], 16'h0000};
        if (op.mfhi)   return model_hi;
        if (op.mflo)   return model_lo;
        return '0;  // mult, divide and moves to HI/LO put nothing on result
    endfunction

    // overflow when the exact signed answer leaves the 32-bit range
    function automatic logic ref_ovf(ovf_chk_t chk, logic [31:0] a, logic [31:0] b);
        longint wide;
        if (chk.add || chk.addi)
            wide = longint'($signed(a)) + longint'($signed(b));
        else if (chk.sub)
            wide = longint'($signed(a)) - longint'($signed(b));
        else
            return 1'b0;
        return (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
    endfunction

    task automatic update_model(input row_t r);
        longint sa;
        longint sb;
        sa = longint'($signed(r.a));
        sb = longint'($signed(r.b));
        if (r.sx != no_ex)
            return;
        if (r.op.mult) begin
            {model_hi, model_lo} = sa * sb;
        end else if (r.op.multu) begin
            {model_hi, model_lo} = {32'h0, r.a} * {32'h0, r.b};
        end else if (r.op.div) begin
            model_lo = 32'(sa / sb);  // truncates toward zero
            model_hi = 32'(sa % sb);
        end else if (r.op.divu) begin
            model_lo = r.a / r.b;
            model_hi = r.a % r.b;
        end else if (r.op.mthi) begin
            model_hi = r.a;
        end else if (r.op.mtlo) begin
            model_lo = r.a;
        end
    endtask

    task automatic fixed_comb(input alu_op_t op, input ovf_chk_t chk, input logic [31:0] a,
                              input logic [31:0] b, input logic [31:0] res, input logic ovf);
        row_t r;
        r     = '0;
        r.op  = op;
        r.chk = chk;
        r.a   = a;
        r.b   = b;
        r.res = res;
        r.ovf = ovf;
        rows.push_back(r);
    endtask

    task automatic fixed_hilo(input alu_op_t op, input stage_ex_t sx, input logic [31:0] a,
                              input logic [31:0] b, input logic [31:0] hi, input logic [31:0] lo);
        row_t r;
        r          = '0;
        r.op       = op;
        r.sx       = sx;
        r.a        = a;
        r.b        = b;
        r.chk_hilo = 1'b1;
        r.hi       = hi;
        r.lo       = lo;
        model_hi   = hi;
        model_lo   = lo;
        rows.push_back(r);
    endtask

    task automatic push_random();
        row_t r;
        int   k;
        r    = '0;
        r.op = alu_op_t'(20'h1 << ($unsigned($random(seed)) % 20));
        r.a  = $random(seed);
        r.b  = $random(seed);
        k    = $unsigned($random(seed)) % 3;
        if (r.op.add) begin
            r.chk.add  = (k == 0);
            r.chk.addi = (k == 1);
        end
        if (r.op.sub)
            r.chk.sub = (k != 2);
        if ((r.op.div || r.op.divu) && r.b == 0)
            r.b = 32'd1;  // divide by zero is out of scope
        if (r.op.mult || r.op.multu || r.op.div || r.op.divu || r.op.mthi || r.op.mtlo) begin
            r.chk_hilo = 1'b1;
            if (($random(seed) & 3) == 0)
                r.sx = stage_ex_t'(4'b1 << ($unsigned($random(seed)) % 4));
        end
        r.res = ref_result(r.op, r.a, r.b);
        r.ovf = ref_ovf(r.chk, r.a, r.b);
        update_model(r);
        r.hi = model_hi;
        r.lo = model_lo;
        rows.push_back(r);
    endtask

    task automatic build_table();
        fixed_comb(op_add,  chk_add,  32'h7fffffff, 32'h00000001, 32'h80000000, 1'b1);
        fixed_comb(op_add,  chk_none, 32'h7fffffff, 32'h00000001, 32'h80000000, 1'b0);
        fixed_comb(op_add,  chk_addi, 32'h40000000, 32'h40000000, 32'h80000000, 1'b1);
        fixed_comb(op_add,  chk_add,  32'hffffffff, 32'h00000001, 32'h00000000, 1'b0);
        fixed_comb(op_sub,  chk_sub,  32'h80000000, 32'h00000001, 32'h7fffffff, 1'b1);
        fixed_comb(op_sub,  chk_sub,  32'hfffffffe, 32'h00000001, 32'hfffffffd, 1'b0);
        fixed_comb(op_slt,  chk_none, 32'hffffffff, 32'h00000001, 32'h00000001, 1'b0);
        fixed_comb(op_sltu, chk_none, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b0);
        fixed_comb(op_slt,  chk_none, 32'h00000001, 32'h80000000, 32'h00000000, 1'b0);
        fixed_comb(op_sltu, chk_none, 32'h00000001, 32'h80000000, 32'h00000001, 1'b0);
        fixed_comb(op_slt,  chk_none, 32'h80000000, 32'h7fffffff, 32'h00000001, 1'b0);
        fixed_comb(op_and,  chk_none, 32'hf0f0f0f0, 32'h3c3c3c3c, 32'h30303030, 1'b0);
        fixed_comb(op_or,   chk_none, 32'hf0f0f0f0, 32'h3c3c3c3c, 32'hfcfcfcfc, 1'b0);
        fixed_comb(op_nor,  chk_none, 32'hf0f0f0f0, 32'h3c3c3c3c, 32'h03030303, 1'b0);
        fixed_comb(op_xor,  chk_none, 32'hf0f0f0f0, 32'h3c3c3c3c, 32'hcccccccc, 1'b0);
        fixed_comb(op_lui,  chk_none, 32'h00000000, 32'h1234abcd, 32'habcd0000, 1'b0);
        fixed_comb(op_sll,  chk_none, 32'h00000000, 32'h87654321, 32'h87654321, 1'b0);
        fixed_comb(op_sll,  chk_none, 32'h0000001f, 32'h00000003, 32'h80000000, 1'b0);
        fixed_comb(op_srl,  chk_none, 32'h0000001f, 32'h80000000, 32'h00000001, 1'b0);
        fixed_comb(op_sra,  chk_none, 32'h0000001f, 32'h80000000, 32'hffffffff, 1'b0);
        fixed_comb(op_sra,  chk_none, 32'h00000004, 32'hf0000000, 32'hff000000, 1'b0);
        fixed_comb(op_srl,  chk_none, 32'h00000004, 32'hf0000000, 32'h0f000000, 1'b0);
        fixed_comb(op_sra,  chk_none, 32'h00000020, 32'h80000001, 32'h80000001, 1'b0);  // bit 5 unused
        fixed_hilo(op_mult,  no_ex,   32'hffffffff, 32'h00000002, 32'hffffffff, 32'hfffffffe);
        fixed_hilo(op_multu, no_ex,   32'hffffffff, 32'hffffffff, 32'hfffffffe, 32'h00000001);
        fixed_hilo(op_mult,  no_ex,   32'h7fffffff, 32'h7fffffff, 32'h3fffffff, 32'h00000001);
        fixed_hilo(op_mult,  4'b0010, 32'h00000005, 32'h00000007, 32'h3fffffff, 32'h00000001);
        fixed_hilo(op_mthi,  no_ex,   32'h12345678, 32'h00000000, 32'h12345678, 32'h00000001);
        fixed_hilo(op_mtlo,  no_ex,   32'h9abcdef0, 32'h00000000, 32'h12345678, 32'h9abcdef0);
        fixed_hilo(op_div,   no_ex,   32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000);
        fixed_hilo(op_div,   no_ex,   32'hfffffff9, 32'h00000002, 32'hffffffff, 32'hfffffffd);
        fixed_hilo(op_div,   no_ex,   32'h00000007, 32'hfffffffe, 32'h00000001, 32'hfffffffd);
        fixed_hilo(op_divu,  no_ex,   32'hfffffff9, 32'h00000002, 32'h00000001, 32'h7ffffffc);
        fixed_hilo(op_divu,  4'b0001, 32'h00000064, 32'h00000007, 32'h00000001, 32'h7ffffffc);
        fixed_hilo(op_div,   4'b1000, 32'h00000064, 32'h00000007, 32'h00000001, 32'h7ffffffc);
        fixed_hilo(op_divu,  no_ex,   32'h00000064, 32'h00000007, 32'h00000002, 32'h0000000e);
        repeat (n_rand) push_random();
    endtask

    task automatic drive(input alu_op_t op, input ovf_chk_t chk, input stage_ex_t sx,
                         input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] res, input logic ovf);
        alu_op     = op;
        ovf_chk    = chk;
        stage_ex   = sx;
        src1       = a;
        src2       = b;
        exp_valid  = 1'b1;
        exp_result = res;
        exp_ovf    = ovf;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic apply_row(input row_t r);
        bit seen;
        int k;
        drive(r.op, r.chk, r.sx, r.a, r.b, r.res, r.ovf);
        if (r.op.div || r.op.divu) begin
            seen = 1'b0;
            for (k = 0; k < div_cycles + 2 && !seen; k++) begin
                next_cycle();
                seen = div_done;
            end
            if (seen)
                next_cycle();  // HI/LO take the result on this edge
            drive('0, chk_none, no_ex, '0, '0, '0, 1'b0);
        end
        next_cycle();
        if (r.chk_hilo) begin
            drive(op_mfhi, chk_none, no_ex, '0, '0, r.hi, 1'b0);
            next_cycle();
            drive(op_mflo, chk_none, no_ex, '0, '0, r.lo, 1'b0);
            next_cycle();
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        alu_op      = '0;
        ovf_chk     = '0;
        stage_ex    = '0;
        src1        = '0;
        src2        = '0;
        exp_valid   = 1'b0;
        exp_result  = '0;
        exp_ovf     = 1'b0;
        model_hi    = '0;
        model_lo    = '0;
        seed        = 32'hc216_fa39;
        build_table();
        limit_ns    = rows.size() * (div_cycles + 4) * 8 + 10 * 8;
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #drive_dly;
        reset = 1'b0;
        foreach (rows[i])
            apply_row(rows[i]);
        exp_valid = 1'b0;
        alu_op    = '0;
        repeat (2) @(posedge clk);
        $display("checks: %0d  errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        #(limit_ns);
        $display("timeout: run still going after %0d ns, %0d errors so far", limit_ns, err_count);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hw/alu_pkg.sv
hw/alu_adder.sv
hw/alu_logic_shift.sv
hw/div_iter.sv
hw/hilo_regs.sv
hw/alu.sv
sim/alu_checker.sv
sim/alu_tb.sv

/* Bender.yml */
package:
  name: mips_alu

sources:
  - hw/alu_pkg.sv
  - hw/alu_adder.sv
  - hw/alu_logic_shift.sv
  - hw/div_iter.sv
  - hw/hilo_regs.sv
  - hw/alu.sv
  - target: simulation
    files:
      - sim/alu_checker.sv
      - sim/alu_tb.sv
